// File: design/exec_params.svh
// execute cluster widths
`ifndef EXEC_PARAMS_SVH
`define EXEC_PARAMS_SVH

`define XLEN        64  // data path
`define ISSUE_WIDTH 2   // slots and lanes
`define INST_W      32

`endif

// File: design/exec_pkg.sv
// execute cluster types
`include "exec_params.svh"

package exec_pkg;

    typedef enum logic [5:0] {
        op_add, op_sub, op_sll, op_slt, op_sltu,
        op_xor, op_srl, op_sra, op_or, op_and,
        op_addw, op_subw, op_sllw, op_srlw, op_sraw,
        op_lui, op_auipc, op_jal, op_jalr,
        op_beq, op_bne, op_blt, op_bge, op_bltu, op_bgeu,
        op_load, op_store,
        op_fence, op_ecall, op_illegal
    } alu_op_e;

    // matches funct3[1:0] of loads and stores
    typedef enum logic [1:0] {
        mem_byte,
        mem_half,
        mem_word,
        mem_double
    } mem_size_e;

    typedef struct packed {
        logic             valid;
        alu_op_e          op;
        logic             b_is_imm;   // second operand is imm, not rs2
        logic [`XLEN-1:0] imm;        // already sign extended
        logic [4:0]       rd;
        logic [31:0]      pc;
        logic [`XLEN-1:0] rs1_value;
        logic [`XLEN-1:0] rs2_value;
        mem_size_e        mem_size;
        logic             mem_unsigned;
    } decoded_op_t;

endpackage

// File: design/lane_if.sv
// per-slot lane interface
`timescale 1ns/1ps
`include "exec_params.svh"

interface lane_if
    import exec_pkg::*;
();

    decoded_op_t      op;

    logic             res_valid;
    logic [4:0]       res_rd;     // zero when nothing is written
    logic             res_wr_en;
    logic [`XLEN-1:0] res_data;
    logic             res_jmp;    // jump or taken branch
    logic [31:0]      res_target;
    logic             res_mem_valid;
    logic             res_mem_store;
    logic [`XLEN-1:0] res_mem_addr;
    logic [`XLEN-1:0] res_store_data;
    mem_size_e        res_mem_size;
    logic             res_ecall;

    modport decode (output op);

    modport lane (
        input  op,
        output res_valid, res_rd, res_wr_en, res_data, res_jmp, res_target,
        output res_mem_valid, res_mem_store, res_mem_addr, res_store_data,
        output res_mem_size, res_ecall
    );

    modport retire (
        input res_valid, res_rd, res_wr_en, res_data, res_jmp, res_target,
        input res_mem_valid, res_mem_store, res_mem_addr, res_store_data,
        input res_mem_size, res_ecall
    );

endinterface

// File: design/issue_decode.sv
// dual slot issue decoder
`timescale 1ns/1ps
`include "exec_params.svh"

module issue_decode
    import exec_pkg::*;
(
    input  logic                                   clk,
    input  logic                                   reset,
    input  logic [`ISSUE_WIDTH-1:0]                i_valid,
    input  logic [`ISSUE_WIDTH-1:0][`INST_W-1:0]   i_inst,
    input  logic [`ISSUE_WIDTH-1:0][31:0]          i_pc,
    input  logic [`ISSUE_WIDTH-1:0][`XLEN-1:0]     i_rs1_value,
    input  logic [`ISSUE_WIDTH-1:0][`XLEN-1:0]     i_rs2_value,
    input  logic                                   i_flush,
    lane_if.decode                                 o_slot [`ISSUE_WIDTH]
);

    // rv64i major opcodes
    typedef enum logic [6:0] {
        opc_load     = 7'h03,
        opc_fence    = 7'h0f,
        opc_op_imm   = 7'h13,
        opc_auipc    = 7'h17,
        opc_op_imm_w = 7'h1b,
        opc_store    = 7'h23,
        opc_op       = 7'h33,
        opc_lui      = 7'h37,
        opc_op_w     = 7'h3b,
        opc_branch   = 7'h63,
        opc_jalr     = 7'h67,
        opc_jal      = 7'h6f,
        opc_system   = 7'h73
    } major_e;

    function automatic decoded_op_t decode_inst(input logic [`INST_W-1:0] inst);
        decoded_op_t d;
        logic [2:0]  f3;
        logic [6:0]  f7;
        major_e      opcode;
        d = '0;
        f3 = inst[14:12];
        f7 = inst[31:25];
        opcode = major_e'(inst[6:0]);
        d.op = op_illegal;
        d.b_is_imm = 1'b1;
        d.imm = {{(`XLEN-12){inst[31]}}, inst[31:20]};  // I form by default
        d.rd = inst[11:7];
        d.mem_size = mem_size_e'(f3[1:0]);
        d.mem_unsigned = f3[2];
        case (opcode)
            opc_op_imm: begin
                case (f3)
                    3'd0: d.op = op_add;
                    3'd1: d.op = (f7[6:1] == 6'h00) ? op_sll : op_illegal;
                    3'd2: d.op = op_slt;
                    3'd3: d.op = op_sltu;
                    3'd4: d.op = op_xor;
                    3'd5: d.op = (f7[6:1] == 6'h00) ? op_srl :
                                 (f7[6:1] == 6'h10) ? op_sra : op_illegal;
                    3'd6: d.op = op_or;
                    default: d.op = op_and;
                endcase
            end
            opc_op: begin
                d.b_is_imm = 1'b0;
                case ({f7, f3})
                    {7'h00, 3'd0}: d.op = op_add;
                    {7'h20, 3'd0}: d.op = op_sub;
                    {7'h00, 3'd1}: d.op = op_sll;
                    {7'h00, 3'd2}: d.op = op_slt;
                    {7'h00, 3'd3}: d.op = op_sltu;
                    {7'h00, 3'd4}: d.op = op_xor;
                    {7'h00, 3'd5}: d.op = op_srl;
                    {7'h20, 3'd5}: d.op = op_sra;
                    {7'h00, 3'd6}: d.op = op_or;
                    {7'h00, 3'd7}: d.op = op_and;
                    default: ;  // mul/div land here
                endcase
            end
            opc_op_imm_w, opc_op_w: begin
                d.b_is_imm = (opcode == opc_op_imm_w);
                case ({f7, f3})
                    {7'h00, 3'd0}: d.op = op_addw;
                    {7'h20, 3'd0}: d.op = op_subw;
                    {7'h00, 3'd1}: d.op = op_sllw;
                    {7'h00, 3'd5}: d.op = op_srlw;
                    {7'h20, 3'd5}: d.op = op_sraw;
                    default: ;
                endcase
                if (d.b_is_imm && f3 == 3'd0) begin
                    d.op = op_addw;  // addiw takes any imm
                end
            end
            opc_lui, opc_auipc: begin
                d.op = (opcode == opc_lui) ? op_lui : op_auipc;
                d.imm = {{(`XLEN-32){inst[31]}}, inst[31:12], 12'd0};
            end
            opc_jal: begin
                d.op = op_jal;
                d.imm = {{(`XLEN-20){inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
            end
            opc_jalr: d.op = (f3 == 3'd0) ? op_jalr : op_illegal;
            opc_branch: begin
                d.b_is_imm = 1'b0;
                d.imm = {{(`XLEN-12){inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
                case (f3)
                    3'd0: d.op = op_beq;
                    3'd1: d.op = op_bne;
                    3'd4: d.op = op_blt;
                    3'd5: d.op = op_bge;
                    3'd6: d.op = op_bltu;
                    3'd7: d.op = op_bgeu;
                    default: ;
                endcase
            end
            opc_load: d.op = (f3 == 3'd7) ? op_illegal : op_load;
            opc_store: begin
                d.op = f3[2] ? op_illegal : op_store;
                d.imm = {{(`XLEN-12){inst[31]}}, inst[31:25], inst[11:7]};
            end
            opc_fence: d.op = op_fence;
            opc_system: d.op = (inst[31:7] == 25'd0) ? op_ecall : op_illegal;
            default: ;
        endcase
        return d;
    endfunction

    for (genvar s = 0; s < `ISSUE_WIDTH; s++) begin : g_slot
        decoded_op_t dec;

        always_comb begin
            dec = decode_inst(i_inst[s]);
            dec.valid = i_valid[s];
            dec.pc = i_pc[s];
            dec.rs1_value = i_rs1_value[s];
            dec.rs2_value = i_rs2_value[s];
        end

        always_ff @(posedge clk) begin
            if (reset || i_flush) begin
                o_slot[s].op.valid <= 1'b0;
            end else begin
                o_slot[s].op <= dec;
            end
        end
    end

endmodule

// File: design/exec_lane.sv
// integer execute lane
`timescale 1ns/1ps
`include "exec_params.svh"

module exec_lane
    import exec_pkg::*;
(
    input  logic  clk,
    input  logic  reset,
    input  logic  i_flush,
    lane_if.lane  slot
);

    decoded_op_t      d;
    logic [`XLEN-1:0] a;
    logic [`XLEN-1:0] b;
    logic [5:0]       shamt;
    logic [`XLEN-1:0] addr;
    logic [`XLEN-1:0] link;
    logic [`XLEN-1:0] result;
    logic [`XLEN-1:0] store_data;
    logic [31:0]      target;
    logic             taken;
    logic             writes;
    logic             is_mem;

    function automatic logic [`XLEN-1:0] sext_w(input logic [31:0] v);
        return {{(`XLEN-32){v[31]}}, v};
    endfunction

    assign d = slot.op;
    assign a = d.rs1_value;
    assign b = d.b_is_imm ? d.imm : d.rs2_value;
    assign shamt = b[5:0];
    assign addr = a + d.imm;  // load/store and jalr
    assign link = `XLEN'(d.pc) + `XLEN'(4);

    always_comb begin
        result = '0;
        taken = 1'b0;
        target = d.pc + d.imm[31:0];
        case (d.op)
            op_add:   result = a + b;
            op_sub:   result = a - b;
            op_sll:   result = a << shamt;
            op_slt:   result = `XLEN'($signed(a) < $signed(b));
            op_sltu:  result = `XLEN'(a < b);
            op_xor:   result = a ^ b;
            op_srl:   result = a >> shamt;
            op_sra:   result = $signed(a) >>> shamt;
            op_or:    result = a | b;
            op_and:   result = a & b;
            op_addw:  result = sext_w(a[31:0] + b[31:0]);
            op_subw:  result = sext_w(a[31:0] - b[31:0]);
            op_sllw:  result = sext_w(a[31:0] << shamt[4:0]);
            op_srlw:  result = sext_w(a[31:0] >> shamt[4:0]);
            op_sraw:  result = sext_w($signed(a[31:0]) >>> shamt[4:0]);
            op_lui:   result = d.imm;
            op_auipc: result = d.imm + `XLEN'(d.pc);
            op_jal: begin
                result = link;
                taken = 1'b1;
            end
            op_jalr: begin
                result = link;
                taken = 1'b1;
                target = {addr[31:1], 1'b0};
            end
            op_beq:   taken = (a == b);
            op_bne:   taken = (a != b);
            op_blt:   taken = ($signed(a) < $signed(b));
            op_bge:   taken = ($signed(a) >= $signed(b));
            op_bltu:  taken = (a < b);
            op_bgeu:  taken = (a >= b);
            default: ;  // memory, fence, ecall, illegal
        endcase
    end

    // store data cut to the access size
    always_comb begin
        case (d.mem_size)
            mem_byte: store_data = `XLEN'(d.rs2_value[7:0]);
            mem_half: store_data = `XLEN'(d.rs2_value[15:0]);
            mem_word: store_data = `XLEN'(d.rs2_value[31:0]);
            default:  store_data = d.rs2_value;
        endcase
    end

    assign is_mem = (d.op inside {op_load, op_store});
    assign writes = d.valid && (d.rd != 5'd0) &&
                    !(d.op inside {op_beq, op_bne, op_blt, op_bge, op_bltu, op_bgeu,
                                   op_load, op_store, op_fence, op_ecall, op_illegal});

    always_ff @(posedge clk) begin
        if (reset || i_flush) begin
            slot.res_valid <= 1'b0;
            slot.res_wr_en <= 1'b0;
            slot.res_jmp <= 1'b0;
            slot.res_mem_valid <= 1'b0;
            slot.res_ecall <= 1'b0;
        end else begin
            slot.res_valid <= d.valid;
            slot.res_wr_en <= writes;
            slot.res_jmp <= d.valid && taken;
            slot.res_mem_valid <= d.valid && is_mem;
            slot.res_ecall <= d.valid && (d.op == op_ecall);
        end
    end

    // payload qualified by the flags above
    always_ff @(posedge clk) begin
        slot.res_rd <= writes ? d.rd : 5'd0;
        slot.res_data <= result;
        slot.res_target <= target;
        slot.res_mem_store <= (d.op == op_store);
        slot.res_mem_addr <= addr;
        slot.res_store_data <= store_data;
        slot.res_mem_size <= d.mem_size;
    end

endmodule

// File: design/retire_merge.sv
// in-order retire merge
`timescale 1ns/1ps
`include "exec_params.svh"

module retire_merge
    import exec_pkg::*;
(
    lane_if.retire                                 i_slot [`ISSUE_WIDTH],
    output logic [`ISSUE_WIDTH-1:0]                o_wr_en,
    output logic [`ISSUE_WIDTH-1:0][4:0]           o_rd,
    output logic [`ISSUE_WIDTH-1:0][`XLEN-1:0]     o_wdata,
    output logic [`ISSUE_WIDTH-1:0]                o_mem_valid,
    output logic [`ISSUE_WIDTH-1:0]                o_mem_store,
    output logic [`ISSUE_WIDTH-1:0][`XLEN-1:0]     o_mem_addr,
    output logic [`ISSUE_WIDTH-1:0][1:0]           o_mem_size,
    output logic [`ISSUE_WIDTH-1:0][`XLEN-1:0]     o_store_data,
    output logic                                   o_redirect,
    output logic [31:0]                            o_redirect_pc,
    output logic                                   o_ecall
);

    logic [`ISSUE_WIDTH-1:0]       valid;
    logic [`ISSUE_WIDTH-1:0]       jmp;
    logic [`ISSUE_WIDTH-1:0]       ecall;
    logic [`ISSUE_WIDTH-1:0][31:0] target;
    logic [`ISSUE_WIDTH-1:0]       live;  // valid and not behind a redirect
    logic                          older_jmp;

    for (genvar s = 0; s < `ISSUE_WIDTH; s++) begin : g_slot
        assign valid[s] = i_slot[s].res_valid;
        assign jmp[s] = i_slot[s].res_jmp;
        assign ecall[s] = i_slot[s].res_ecall;
        assign target[s] = i_slot[s].res_target;

        assign o_wr_en[s] = live[s] && i_slot[s].res_wr_en;
        assign o_rd[s] = o_wr_en[s] ? i_slot[s].res_rd : 5'd0;
        assign o_wdata[s] = i_slot[s].res_data;
        assign o_mem_valid[s] = live[s] && i_slot[s].res_mem_valid;
        assign o_mem_store[s] = o_mem_valid[s] && i_slot[s].res_mem_store;
        assign o_mem_addr[s] = i_slot[s].res_mem_addr;
        assign o_mem_size[s] = i_slot[s].res_mem_size;
        assign o_store_data[s] = i_slot[s].res_store_data;
    end

    // first live jump from the oldest slot wins
    always_comb begin
        older_jmp = 1'b0;
        o_redirect = 1'b0;
        o_redirect_pc = '0;
        o_ecall = 1'b0;
        for (int s = 0; s < `ISSUE_WIDTH; s++) begin
            live[s] = valid[s] && !older_jmp;
            if (live[s] && jmp[s]) begin
                o_redirect = 1'b1;
                o_redirect_pc = target[s];
            end
            o_ecall = o_ecall || (live[s] && ecall[s]);
            older_jmp = older_jmp || (live[s] && jmp[s]);
        end
    end

endmodule

// File: design/exec_cluster.sv
// two-wide rv64i execute cluster
`timescale 1ns/1ps
`include "exec_params.svh"

module exec_cluster (
    input  logic                                   clk,
    input  logic                                   reset,
    input  logic [`ISSUE_WIDTH-1:0]                i_valid,
    input  logic [`ISSUE_WIDTH-1:0][`INST_W-1:0]   i_inst,
    input  logic [`ISSUE_WIDTH-1:0][31:0]          i_pc,
    input  logic [`ISSUE_WIDTH-1:0][`XLEN-1:0]     i_rs1_value,
    input  logic [`ISSUE_WIDTH-1:0][`XLEN-1:0]     i_rs2_value,
    input  logic                                   i_flush,
    output logic [`ISSUE_WIDTH-1:0]                o_wr_en,
    output logic [`ISSUE_WIDTH-1:0][4:0]           o_rd,
    output logic [`ISSUE_WIDTH-1:0][`XLEN-1:0]     o_wdata,
    output logic [`ISSUE_WIDTH-1:0]                o_mem_valid,
    output logic [`ISSUE_WIDTH-1:0]                o_mem_store,
    output logic [`ISSUE_WIDTH-1:0][`XLEN-1:0]     o_mem_addr,
    output logic [`ISSUE_WIDTH-1:0][1:0]           o_mem_size,
    output logic [`ISSUE_WIDTH-1:0][`XLEN-1:0]     o_store_data,
    output logic                                   o_redirect,
    output logic [31:0]                            o_redirect_pc,
    output logic                                   o_ecall
);

    lane_if slot_bus [`ISSUE_WIDTH] ();  // one per slot

    issue_decode u_decode (
        .clk         (clk),
        .reset       (reset),
        .i_valid     (i_valid),
        .i_inst      (i_inst),
        .i_pc        (i_pc),
        .i_rs1_value (i_rs1_value),
        .i_rs2_value (i_rs2_value),
        .i_flush     (i_flush),
        .o_slot      (slot_bus)
    );

    for (genvar g = 0; g < `ISSUE_WIDTH; g++) begin : g_lane
        exec_lane u_lane (
            .clk     (clk),
            .reset   (reset),
            .i_flush (i_flush),
            .slot    (slot_bus[g])
        );
    end

    retire_merge u_merge (
        .i_slot        (slot_bus),
        .o_wr_en       (o_wr_en),
        .o_rd          (o_rd),
        .o_wdata       (o_wdata),
        .o_mem_valid   (o_mem_valid),
        .o_mem_store   (o_mem_store),
        .o_mem_addr    (o_mem_addr),
        .o_mem_size    (o_mem_size),
        .o_store_data  (o_store_data),
        .o_redirect    (o_redirect),
        .o_redirect_pc (o_redirect_pc),
        .o_ecall       (o_ecall)
    );

endmodule

// File: testbench/exec_ref_model.svh
// execute cluster reference model
`ifndef EXEC_REF_MODEL_SVH
`define EXEC_REF_MODEL_SVH

typedef struct packed {
    logic        wr;
    logic [4:0]  rd;
    logic [63:0] wdata;
    logic        jmp;     // jump or taken branch
    logic [31:0] target;
    logic        mem;
    logic        store;
    logic [63:0] addr;
    logic [1:0]  size;
    logic [63:0] sdata;
    logic        ecall;
} slot_exp_t;

typedef struct packed {
    slot_exp_t   s1;
    slot_exp_t   s0;
    logic        redirect;
    logic [31:0] redirect_pc;
    logic        ecall;
} pair_exp_t;

// fibonacci lfsr with taps 32 22 2 1
function automatic logic [63:0] rand_bits(input int n);
    logic [63:0] r;
    logic        fb;
    r = '0;
    for (int i = 0; i < n; i++) begin
        fb = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
        lfsr_q = {lfsr_q[30:0], fb};
        r = {r[62:0], fb};
    end
    return r;
endfunction

function automatic logic [63:0] imm_i(input logic [31:0] inst);
    return {{52{inst[31]}}, inst[31:20]};
endfunction

function automatic logic [63:0] imm_s(input logic [31:0] inst);
    return {{52{inst[31]}}, inst[31:25], inst[11:7]};
endfunction

function automatic logic [63:0] imm_b(input logic [31:0] inst);
    return {{52{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
endfunction

function automatic logic [63:0] imm_u(input logic [31:0] inst);
    return {{32{inst[31]}}, inst[31:12], 12'd0};
endfunction

function automatic logic [63:0] imm_j(input logic [31:0] inst);
    return {{44{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
endfunction

function automatic logic [63:0] alu_model(input logic [2:0] f3, input logic alt,
                                          input logic word, input logic [63:0] a,
                                          input logic [63:0] b);
    logic [63:0] r;
    logic [31:0] w;
    if (word) begin
        if (f3 == 3'd1) w = a[31:0] << b[4:0];
        else if (f3 == 3'd5 && alt) w = $signed(a[31:0]) >>> b[4:0];
        else if (f3 == 3'd5) w = a[31:0] >> b[4:0];
        else if (alt) w = a[31:0] - b[31:0];
        else w = a[31:0] + b[31:0];
        return {{32{w[31]}}, w};
    end
    case (f3)
        3'd0: r = alt ? a - b : a + b;
        3'd1: r = a << b[5:0];
        3'd2: r = {63'd0, $signed(a) < $signed(b)};
        3'd3: r = {63'd0, a < b};
        3'd4: r = a ^ b;
        3'd5: begin
            if (alt) r = $signed(a) >>> b[5:0];
            else r = a >> b[5:0];
        end
        3'd6: r = a | b;
        default: r = a & b;
    endcase
    return r;
endfunction

function automatic logic branch_taken(input logic [2:0] f3, input logic [63:0] a,
                                      input logic [63:0] b);
    case (f3)
        3'd0: return a == b;
        3'd1: return a != b;
        3'd4: return $signed(a) < $signed(b);
        3'd5: return $signed(a) >= $signed(b);
        3'd6: return a < b;
        3'd7: return a >= b;
        default: return 1'b0;
    endcase
endfunction

function automatic slot_exp_t slot_model(input logic v, input logic [31:0] inst,
                                         input logic [31:0] pc, input logic [63:0] rs1,
                                         input logic [63:0] rs2);
    slot_exp_t   e;
    logic [2:0]  f3;
    logic [63:0] imm;
    logic [63:0] addr;
    logic [63:0] link;
    logic        wr;
    e = '0;
    if (!v) return e;
    f3 = inst[14:12];
    wr = 1'b0;
    link = {32'd0, pc} + 64'd4;
    case (inst[6:0])
        7'h13, 7'h1b: begin
            wr = 1'b1;
            e.wdata = alu_model(f3, f3 == 3'd5 && inst[30], inst[3], rs1, imm_i(inst));
        end
        7'h33, 7'h3b: begin
            wr = (inst[31:25] == 7'h00) || (inst[31:25] == 7'h20);  // mul/div excluded
            e.wdata = alu_model(f3, inst[30], inst[3], rs1, rs2);
        end
        7'h37, 7'h17: begin
            wr = 1'b1;
            e.wdata = inst[5] ? imm_u(inst) : imm_u(inst) + {32'd0, pc};
        end
        7'h6f: begin
            imm = imm_j(inst);
            wr = 1'b1;
            e.wdata = link;
            e.jmp = 1'b1;
            e.target = pc + imm[31:0];
        end
        7'h67: begin
            addr = rs1 + imm_i(inst);
            wr = 1'b1;
            e.wdata = link;
            e.jmp = 1'b1;
            e.target = {addr[31:1], 1'b0};
        end
        7'h63: begin
            imm = imm_b(inst);
            e.jmp = branch_taken(f3, rs1, rs2);
            e.target = pc + imm[31:0];
        end
        7'h03, 7'h23: begin
            e.mem = 1'b1;
            e.store = inst[5];
            e.addr = rs1 + (inst[5] ? imm_s(inst) : imm_i(inst));
            e.size = f3[1:0];
            case (f3[1:0])
                2'd0: e.sdata = {56'd0, rs2[7:0]};
                2'd1: e.sdata = {48'd0, rs2[15:0]};
                2'd2: e.sdata = {32'd0, rs2[31:0]};
                default: e.sdata = rs2;
            endcase
        end
        7'h73: e.ecall = (inst[31:7] == 25'd0);
        default: ;  // fence and unknown opcodes do nothing
    endcase
    e.wr = wr && (inst[11:7] != 5'd0);
    e.rd = e.wr ? inst[11:7] : 5'd0;
    return e;
endfunction

// a redirect in the older slot 0 squashes slot 1
function automatic pair_exp_t pair_model(input slot_exp_t a, input slot_exp_t b);
    pair_exp_t p;
    p = '0;
    p.s0 = a;
    if (!a.jmp) p.s1 = b;
    p.redirect = a.jmp || p.s1.jmp;
    p.redirect_pc = a.jmp ? a.target : p.s1.target;
    p.ecall = a.ecall || p.s1.ecall;
    return p;
endfunction

`endif

// File: testbench/tb_exec_cluster.sv
// execute cluster testbench
`timescale 1ns/1ps
`include "exec_params.svh"

module tb_exec_cluster;

    localparam int NUM_PAIRS = 400;
    localparam int TIMEOUT_CYCLES = NUM_PAIRS + 24;  // reset, drain and margin

    logic                                 clk;
    logic                                 reset;
    logic [`ISSUE_WIDTH-1:0]              i_valid;
    logic [`ISSUE_WIDTH-1:0][`INST_W-1:0] i_inst;
    logic [`ISSUE_WIDTH-1:0][31:0]        i_pc;
    logic [`ISSUE_WIDTH-1:0][`XLEN-1:0]   i_rs1_value;
    logic [`ISSUE_WIDTH-1:0][`XLEN-1:0]   i_rs2_value;
    logic                                 i_flush;
    logic [`ISSUE_WIDTH-1:0]              o_wr_en;
    logic [`ISSUE_WIDTH-1:0][4:0]         o_rd;
    logic [`ISSUE_WIDTH-1:0][`XLEN-1:0]   o_wdata;
    logic [`ISSUE_WIDTH-1:0]              o_mem_valid;
    logic [`ISSUE_WIDTH-1:0]              o_mem_store;
    logic [`ISSUE_WIDTH-1:0][`XLEN-1:0]   o_mem_addr;
    logic [`ISSUE_WIDTH-1:0][1:0]         o_mem_size;
    logic [`ISSUE_WIDTH-1:0][`XLEN-1:0]   o_store_data;
    logic                                 o_redirect;
    logic [31:0]                          o_redirect_pc;
    logic                                 o_ecall;

    logic [31:0] lfsr_q;
    int          errors;
    int          checked;
    int          cycles;

`include "exec_ref_model.svh"

    pair_exp_t exp_q [$];  // two pairs in flight

    exec_cluster dut (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    initial begin
        cycles = 0;
        while (cycles < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycles++;
        end
        $display("run did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("STATUS: FAIL");
        $finish;
    end

    task automatic expect_eq(input string name, input logic [63:0] got,
                             input logic [63:0] exp);
        assert (got === exp) else begin
            $display("FAILED %s: got %h expected %h", name, got, exp);
            errors++;
        end
    endtask

    function automatic logic [31:0] make_inst(input logic [3:0] kind);
        logic [4:0]  rd;
        logic [4:0]  rs1f;
        logic [4:0]  rs2f;
        logic [2:0]  f3;
        logic [6:0]  f7;
        logic [11:0] hi;
        logic        alt;
        logic [31:0] inst;
        rd = 5'(rand_bits(5));
        rs1f = 5'(rand_bits(5));
        rs2f = 5'(rand_bits(5));
        f3 = 3'(rand_bits(3));
        hi = 12'(rand_bits(12));
        alt = (rand_bits(1) != 64'd0);
        case (kind)
            4'd0, 4'd1: begin
                if (f3 == 3'd1 || f3 == 3'd5) hi[11:6] = (f3 == 3'd5 && alt) ? 6'h10 : 6'h00;
                inst = {hi, rs1f, f3, rd, 7'h13};
            end
            4'd2, 4'd3: begin
                f7 = ((f3 == 3'd0 || f3 == 3'd5) && alt) ? 7'h20 : 7'h00;
                inst = {f7, rs2f, rs1f, f3, rd, 7'h33};
            end
            4'd4, 4'd5: begin
                f3 = (f3[1:0] == 2'd0) ? 3'd0 : (f3[1:0] == 2'd1) ? 3'd1 : 3'd5;
                f7 = (f3 != 3'd1 && alt) ? 7'h20 : 7'h00;
                if (kind == 4'd4 && f3 != 3'd0) hi = {f7, rs2f};  // 5-bit shamt
                inst = (kind == 4'd4) ? {hi, rs1f, f3, rd, 7'h1b} : {f7, rs2f, rs1f, f3, rd, 7'h3b};
            end
            4'd6: inst = {20'(rand_bits(20)), rd, alt ? 7'h37 : 7'h17};
            4'd7: inst = {20'(rand_bits(20)), rd, 7'h6f};
            4'd8: inst = {hi, rs1f, 3'd0, rd, 7'h67};
            4'd9, 4'd10: begin
                if (f3[2:1] == 2'b01) f3[2] = 1'b1;  // no branch funct3 2 or 3
                inst = {hi[11:5], rs2f, rs1f, f3, hi[4:0], 7'h63};
            end
            4'd11: inst = {hi, rs1f, (f3 == 3'd7) ? 3'd3 : f3, rd, 7'h03};
            4'd12: inst = {hi[11:5], rs2f, rs1f, 1'b0, f3[1:0], hi[4:0], 7'h23};
            4'd13: inst = {12'h0ff, 5'd0, 3'd0, rd, 7'h0f};
            4'd14: inst = 32'h00000073;
            default: inst = alt ? {7'h01, rs2f, rs1f, f3, rd, 7'h33} : {25'(rand_bits(25)), 7'h00};
        endcase
        return inst;
    endfunction

    task automatic drive_pair();
        slot_exp_t   e [2];
        logic [63:0] rs1;
        logic [63:0] rs2;
        for (int s = 0; s < 2; s++) begin
            i_valid[s] = (rand_bits(2) != 64'd0);
            i_inst[s] = make_inst(4'(rand_bits(4)));
            i_pc[s] = {30'(rand_bits(30)), 2'b00};
            rs1 = rand_bits(64);
            rs2 = (rand_bits(2) == 64'd0) ? rs1 : rand_bits(64);  // equal now and then
            i_rs1_value[s] = rs1;
            i_rs2_value[s] = rs2;
            e[s] = slot_model(i_valid[s], i_inst[s], i_pc[s], rs1, rs2);
        end
        i_flush = (rand_bits(5) == 64'd0);
        if (i_flush) begin
            if (exp_q.size() > 0) exp_q[exp_q.size()-1] = '0;
            exp_q.push_back('0);
        end else begin
            exp_q.push_back(pair_model(e[0], e[1]));
        end
    endtask

    task automatic check_pair(input pair_exp_t e);
        slot_exp_t x;
        for (int s = 0; s < 2; s++) begin
            x = (s == 0) ? e.s0 : e.s1;
            expect_eq($sformatf("o_wr_en[%0d]", s), 64'(o_wr_en[s]), 64'(x.wr));
            expect_eq($sformatf("o_rd[%0d]", s), 64'(o_rd[s]), 64'(x.rd));
            if (x.wr) expect_eq($sformatf("o_wdata[%0d]", s), o_wdata[s], x.wdata);
            expect_eq($sformatf("o_mem_valid[%0d]", s), 64'(o_mem_valid[s]), 64'(x.mem));
            if (x.mem) begin
                expect_eq($sformatf("o_mem_store[%0d]", s), 64'(o_mem_store[s]), 64'(x.store));
                expect_eq($sformatf("o_mem_addr[%0d]", s), o_mem_addr[s], x.addr);
                expect_eq($sformatf("o_mem_size[%0d]", s), 64'(o_mem_size[s]), 64'(x.size));
                if (x.store) expect_eq($sformatf("o_store_data[%0d]", s), o_store_data[s], x.sdata);
            end
        end
        expect_eq("o_redirect", 64'(o_redirect), 64'(e.redirect));
        if (e.redirect) expect_eq("o_redirect_pc", 64'(o_redirect_pc), 64'(e.redirect_pc));
        expect_eq("o_ecall", 64'(o_ecall), 64'(e.ecall));
        checked++;
    endtask

    initial begin
        errors = 0;
        checked = 0;
        lfsr_q = 32'd7;
        reset = 1'b1;
        i_valid = '0;
        i_inst = '0;
        i_pc = '0;
        i_rs1_value = '0;
        i_rs2_value = '0;
        i_flush = 1'b0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        expect_eq("o_wr_en after reset", 64'(o_wr_en), 64'd0);
        expect_eq("o_mem_valid after reset", 64'(o_mem_valid), 64'd0);
        expect_eq("o_redirect after reset", 64'(o_redirect), 64'd0);
        expect_eq("o_ecall after reset", 64'(o_ecall), 64'd0);
        for (int n = 0; n < NUM_PAIRS + 2; n++) begin
            if (exp_q.size() == 2) check_pair(exp_q.pop_front());
            if (n < NUM_PAIRS) begin
                drive_pair();
            end else begin
                i_valid = '0;  // drain
                i_flush = 1'b0;
                exp_q.push_back('0);
            end
            @(negedge clk);
        end
        $display("errors: %0d, pairs checked: %0d", errors, checked);
        if (errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

// File: vlog.f
+incdir+design
+incdir+testbench
design/exec_pkg.sv
design/lane_if.sv
design/issue_decode.sv
design/exec_lane.sv
design/retire_merge.sv
design/exec_cluster.sv
testbench/tb_exec_cluster.sv
